//--- usb_in_ep_defs.svh
// Shared constants for the USB IN endpoint
// Bit timing, buffer size, device address, PID codes, CRC polynomials
`ifndef USB_IN_EP_DEFS_SVH
`define USB_IN_EP_DEFS_SVH

// ****************************************
// Line timing
// ****************************************
// Clocks per USB bit
`define USB_BIT_CYCLES      4
// Bit times from token EOP to response start
`define USB_TURNAROUND_BITS 4
// Ones before a stuffed zero
`define USB_STUFF_RUN       6

// ****************************************
// Endpoint identity and storage
// ****************************************
`define USB_BUF_DEPTH       64
`define USB_DEV_ADDR        7'h05
`define USB_EP_NUM          4'h1

// ****************************************
// Packet framing
// ****************************************
`define USB_SYNC_BYTE       8'h01
`define USB_PID_OUT         4'b0001
`define USB_PID_IN          4'b1001
`define USB_PID_DATA0       4'b0011
`define USB_PID_NAK         4'b1010
`define USB_CRC5_POLY       5'b00101
`define USB_CRC16_POLY      16'h8005

`endif

//--- usb_pkg.sv
// Types shared by the endpoint blocks
// PID codes, byte type, token field union
`include "usb_in_ep_defs.svh"

package usb_pkg;

  // Token and handshake PIDs used by this endpoint
  typedef enum logic [3:0] {
    PID_OUT   = `USB_PID_OUT,
    PID_IN    = `USB_PID_IN,
    PID_DATA0 = `USB_PID_DATA0,
    PID_NAK   = `USB_PID_NAK
  } usb_pid_t;

  typedef logic [7:0] byte_t;

  // Token fields after the PID, MSB first on the line
  typedef struct packed {
    logic [6:0] addr;
    logic [3:0] endp;
    logic [4:0] crc5;
  } usb_token_fields_t;

  // Same 16 bits seen as two line bytes
  // b[1] arrives first, b[0] second
  typedef union packed {
    usb_token_fields_t f;
    byte_t [1:0]       b;
  } usb_token_u;

endpackage

//--- token_rx.sv
// Host token receiver
// NRZI decode, unstuffing, sync hunt, PID and CRC5 check, address match
`timescale 1ns/100ps
`include "usb_in_ep_defs.svh"

module token_rx (
  input  logic tb_clk,
  input  logic reset,
  input  logic dplus_in,
  input  logic dminus_in,
  output logic in_token_seen
);
  import usb_pkg::*;

  localparam int PHASE_W  = $clog2(`USB_BIT_CYCLES);
  localparam int HALF_BIT = `USB_BIT_CYCLES / 2;
  localparam int RUN_W    = $clog2(`USB_STUFF_RUN + 1);

  // Receiver states
  localparam logic [1:0] RX_HUNT  = 2'd0;
  localparam logic [1:0] RX_PID   = 2'd1;
  localparam logic [1:0] RX_TOKEN = 2'd2;
  localparam logic [1:0] RX_EOP   = 2'd3;

  logic               dp_q;
  logic               dm_q;
  logic               dp_d;
  logic               dm_d;
  logic [PHASE_W-1:0] phase;
  logic               line_edge;
  logic               sample;
  logic               se0;
  logic               nrzi_bit;
  logic               last_dp;
  logic [RUN_W-1:0]   ones_run;
  logic [1:0]         state;
  logic [7:0]         sh;
  logic [7:0]         sh_next;
  logic [3:0]         bit_cnt;
  logic               pid_ok;
  logic [4:0]         crc5;
  logic [4:0]         crc5_next;
  logic               se0_seen;
  logic               tok_match;
  usb_token_u         tok;

  // ****************************************
  // Line sampling and bit phase
  // ****************************************
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      // Idle bus is J
      dp_q <= 1'b1;
      dm_q <= 1'b0;
      dp_d <= 1'b1;
      dm_d <= 1'b0;
    end else begin
      dp_q <= dplus_in;
      dm_q <= dminus_in;
      dp_d <= dp_q;
      dm_d <= dm_q;
    end
  end

  assign line_edge = (dp_q != dp_d) || (dm_q != dm_d);

  // Phase restarts on every level change, wraps on long runs
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      phase <= '0;
    end else if (line_edge) begin
      phase <= PHASE_W'(1);
    end else if (phase == PHASE_W'(`USB_BIT_CYCLES - 1)) begin
      phase <= '0;
    end else begin
      phase <= phase + PHASE_W'(1);
    end
  end

  // Mid-bit strobe
  assign sample   = !line_edge && (phase == PHASE_W'(HALF_BIT));
  assign se0      = !dp_q && !dm_q;
  // No change since last bit means one
  assign nrzi_bit = (dp_q == last_dp);
  assign sh_next  = {sh[6:0], nrzi_bit};

  // Serial CRC5 over address and endpoint
  assign crc5_next = {crc5[3:0], 1'b0} ^ ((nrzi_bit ^ crc5[4]) ? `USB_CRC5_POLY : 5'd0);

  assign tok_match = pid_ok &&
                     (tok.f.crc5 == ~crc5) &&
                     (tok.f.addr == `USB_DEV_ADDR) &&
                     (tok.f.endp == `USB_EP_NUM);

  // ****************************************
  // Packet FSM
  // ****************************************
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      state         <= RX_HUNT;
      sh            <= 8'hff;
      bit_cnt       <= '0;
      ones_run      <= '0;
      last_dp       <= 1'b1;
      pid_ok        <= 1'b0;
      crc5          <= '1;
      se0_seen      <= 1'b0;
      in_token_seen <= 1'b0;
    end else begin
      in_token_seen <= 1'b0;
      if (sample) begin
        if (se0) begin
          // SE0 only legal where the EOP belongs
          if (state == RX_EOP) begin
            se0_seen <= 1'b1;
          end else if (state != RX_HUNT) begin
            state <= RX_HUNT;
            sh    <= 8'hff;
          end
        end else begin
          last_dp <= dp_q;
          if (state == RX_HUNT) begin
            sh <= sh_next;
            if (sh_next == `USB_SYNC_BYTE) begin
              state    <= RX_PID;
              bit_cnt  <= '0;
              // Sync ends in a single one
              ones_run <= RUN_W'(1);
              crc5     <= '1;
              se0_seen <= 1'b0;
            end
          end else if (state == RX_EOP && se0_seen) begin
            // J closes the EOP
            in_token_seen <= dp_q && tok_match;
            state         <= RX_HUNT;
            sh            <= 8'hff;
          end else if (ones_run == RUN_W'(`USB_STUFF_RUN)) begin
            // Stuffed zero dropped, a one here is a stuff error
            ones_run <= '0;
            if (nrzi_bit) begin
              state <= RX_HUNT;
              sh    <= 8'hff;
            end
          end else begin
            ones_run <= nrzi_bit ? ones_run + RUN_W'(1) : '0;
            sh       <= sh_next;
            bit_cnt  <= bit_cnt + 4'd1;
            case (state)
              RX_PID: begin
                if (bit_cnt == 4'd7) begin
                  // Check nibble and accept IN only
                  pid_ok  <= (sh_next[7:4] == ~sh_next[3:0]) && (sh_next[7:4] == PID_IN);
                  bit_cnt <= '0;
                  state   <= RX_TOKEN;
                end
              end
              RX_TOKEN: begin
                if (bit_cnt < 4'd11) begin
                  crc5 <= crc5_next;
                end
                // Fill union one line byte at a time
                if (bit_cnt[2:0] == 3'd7) begin
                  if (bit_cnt[3]) begin
                    tok.b[0] <= sh_next;
                  end else begin
                    tok.b[1] <= sh_next;
                  end
                end
                if (bit_cnt == 4'd15) begin
                  state <= RX_EOP;
                end
              end
              default: begin
                // Extra bit where EOP expected
                state <= RX_HUNT;
                sh    <= 8'hff;
              end
            endcase
          end
        end
      end
    end
  end

endmodule

//--- payload_buf.sv
// Payload byte buffer
// Valid/ready load port, read head for the transmitter
`timescale 1ns/100ps
`include "usb_in_ep_defs.svh"

module payload_buf (
  input  logic           tb_clk,
  input  logic           reset,
  input  usb_pkg::byte_t in_data,
  input  logic           in_valid,
  output logic           in_ready,
  input  logic           tx_busy,
  input  logic           buf_pop,
  output usb_pkg::byte_t buf_data,
  output logic [6:0]     buf_count
);
  import usb_pkg::*;

  localparam int PTR_W = $clog2(`USB_BUF_DEPTH);

  byte_t            mem [`USB_BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             push;
  logic             pop;

  assign full     = (buf_count == 7'(`USB_BUF_DEPTH));
  // Loading held off while a packet goes out
  assign in_ready = !full && !tx_busy;
  assign push     = in_valid && in_ready;
  assign pop      = buf_pop && (buf_count != 7'd0);

  // Storage
  always_ff @(posedge tb_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  assign buf_data = mem[rd_ptr];

  // Pointers and count
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      buf_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   buf_count <= buf_count + 7'd1;
        2'b01:   buf_count <= buf_count - 7'd1;
        default: buf_count <= buf_count;
      endcase
      // Last byte out, next packet starts at the bottom
      if (pop && !push && buf_count == 7'd1) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end
    end
  end

endmodule

//--- packet_tx.sv
// Response packet builder
// Turnaround wait, DATA0 or NAK framing, CRC16, stuffing, NRZI, EOP
`timescale 1ns/100ps
`include "usb_in_ep_defs.svh"

module packet_tx (
  input  logic           tb_clk,
  input  logic           reset,
  input  logic           in_token_seen,
  input  logic [6:0]     buf_count,
  input  usb_pkg::byte_t buf_data,
  output logic           buf_pop,
  output logic           tx_busy,
  output logic           dplus_out,
  output logic           dminus_out,
  output logic           d_mode
);
  import usb_pkg::*;

  localparam int CYC_W   = $clog2(`USB_BIT_CYCLES);
  localparam int TA_CLKS = `USB_TURNAROUND_BITS * `USB_BIT_CYCLES;
  localparam int TA_W    = $clog2(TA_CLKS);
  localparam int RUN_W   = $clog2(`USB_STUFF_RUN + 1);

  // Transmit states
  localparam logic [1:0] TX_IDLE = 2'd0;
  localparam logic [1:0] TX_WAIT = 2'd1;
  localparam logic [1:0] TX_SEND = 2'd2;
  localparam logic [1:0] TX_EOP  = 2'd3;

  // Byte currently in the shifter
  localparam logic [2:0] FLD_SYNC   = 3'd0;
  localparam logic [2:0] FLD_PID    = 3'd1;
  localparam logic [2:0] FLD_DATA   = 3'd2;
  localparam logic [2:0] FLD_CRC_HI = 3'd3;
  localparam logic [2:0] FLD_CRC_LO = 3'd4;
  localparam logic [2:0] FLD_END    = 3'd5;

  logic [1:0]       state;
  logic [CYC_W-1:0] cyc;
  logic             bit_tick;
  logic [TA_W-1:0]  ta_cnt;
  logic [7:0]       sh;
  logic [2:0]       bit_idx;
  logic [2:0]       fld;
  logic [RUN_W-1:0] ones_run;
  logic [6:0]       n_left;
  logic [15:0]      crc16;
  logic [15:0]      crc16_next;
  usb_pid_t         tx_pid;
  byte_t            pid_byte;
  logic [1:0]       eop_cnt;

  assign bit_tick   = (cyc == CYC_W'(`USB_BIT_CYCLES - 1));
  // PID in high nibble, check nibble below
  assign pid_byte   = {tx_pid, ~tx_pid};
  assign crc16_next = {crc16[14:0], 1'b0} ^
                      ((sh[7] ^ crc16[15]) ? `USB_CRC16_POLY : 16'h0000);

  always_ff @(posedge tb_clk) begin
    if (reset) begin
      state      <= TX_IDLE;
      cyc        <= '0;
      ta_cnt     <= '0;
      sh         <= '0;
      bit_idx    <= '0;
      fld        <= FLD_SYNC;
      ones_run   <= '0;
      n_left     <= '0;
      crc16      <= '1;
      tx_pid     <= PID_NAK;
      eop_cnt    <= '0;
      buf_pop    <= 1'b0;
      tx_busy    <= 1'b0;
      d_mode     <= 1'b0;
      dplus_out  <= 1'b1;
      dminus_out <= 1'b0;
    end else begin
      buf_pop <= 1'b0;
      // Bit clock runs only while driving
      if (state == TX_SEND || state == TX_EOP) begin
        cyc <= bit_tick ? '0 : cyc + CYC_W'(1);
      end
      case (state)
        TX_IDLE: begin
          if (in_token_seen) begin
            state   <= TX_WAIT;
            ta_cnt  <= '0;
            tx_busy <= 1'b1;
          end
        end
        TX_WAIT: begin
          ta_cnt <= ta_cnt + TA_W'(1);
          if (ta_cnt == TA_W'(TA_CLKS - 1)) begin
            // Take the bus, line holds J for one bit first
            state    <= TX_SEND;
            d_mode   <= 1'b1;
            cyc      <= '0;
            sh       <= `USB_SYNC_BYTE;
            fld      <= FLD_SYNC;
            bit_idx  <= '0;
            ones_run <= '0;
            crc16    <= '1;
            n_left   <= buf_count;
            tx_pid   <= (buf_count != 7'd0) ? PID_DATA0 : PID_NAK;
          end
        end
        TX_SEND: begin
          if (bit_tick) begin
            if (ones_run == RUN_W'(`USB_STUFF_RUN)) begin
              // Stuffed zero, data does not advance
              dplus_out  <= ~dplus_out;
              dminus_out <= ~dminus_out;
              ones_run   <= '0;
            end else if (fld == FLD_END) begin
              // First SE0 bit
              dplus_out  <= 1'b0;
              dminus_out <= 1'b0;
              eop_cnt    <= '0;
              state      <= TX_EOP;
            end else begin
              // Zero toggles the line, one holds it
              if (!sh[7]) begin
                dplus_out  <= ~dplus_out;
                dminus_out <= ~dminus_out;
              end
              ones_run <= sh[7] ? ones_run + RUN_W'(1) : '0;
              if (fld == FLD_DATA) begin
                crc16 <= crc16_next;
              end
              sh      <= {sh[6:0], 1'b0};
              bit_idx <= bit_idx + 3'd1;
              // Byte boundary, load the next field
              if (bit_idx == 3'd7) begin
                case (fld)
                  FLD_SYNC: begin
                    sh  <= pid_byte;
                    fld <= FLD_PID;
                  end
                  FLD_PID, FLD_DATA: begin
                    if (n_left != 7'd0) begin
                      sh      <= buf_data;
                      buf_pop <= 1'b1;
                      n_left  <= n_left - 7'd1;
                      fld     <= FLD_DATA;
                    end else if (fld == FLD_DATA) begin
                      // CRC includes the bit just sent
                      sh  <= ~crc16_next[15:8];
                      fld <= FLD_CRC_HI;
                    end else begin
                      fld <= FLD_END;
                    end
                  end
                  FLD_CRC_HI: begin
                    sh  <= ~crc16[7:0];
                    fld <= FLD_CRC_LO;
                  end
                  default: fld <= FLD_END;
                endcase
              end
            end
          end
        end
        default: begin
          // Two SE0 bits, one J bit, then release
          if (bit_tick) begin
            eop_cnt <= eop_cnt + 2'd1;
            if (eop_cnt == 2'd1) begin
              dplus_out  <= 1'b1;
              dminus_out <= 1'b0;
            end
            if (eop_cnt == 2'd2) begin
              d_mode  <= 1'b0;
              tx_busy <= 1'b0;
              state   <= TX_IDLE;
            end
          end
        end
      endcase
    end
  end

endmodule

//--- usb_in_ep.sv
// Full-speed USB IN endpoint top level
// Token receiver, payload buffer, packet transmitter
`timescale 1ns/100ps

module usb_in_ep (
  input  logic           tb_clk,
  input  logic           reset,
  input  usb_pkg::byte_t in_data,
  input  logic           in_valid,
  output logic           in_ready,
  input  logic           dplus_in,
  input  logic           dminus_in,
  output logic           dplus_out,
  output logic           dminus_out,
  output logic           d_mode
);
  import usb_pkg::*;

  // Receiver to transmitter
  logic       in_token_seen;
  // Buffer and transmitter handshake
  logic [6:0] buf_count;
  byte_t      buf_data;
  logic       buf_pop;
  logic       tx_busy;

  token_rx u_token_rx (
    .tb_clk       (tb_clk),
    .reset        (reset),
    .dplus_in     (dplus_in),
    .dminus_in    (dminus_in),
    .in_token_seen(in_token_seen)
  );

  payload_buf u_payload_buf (
    .tb_clk   (tb_clk),
    .reset    (reset),
    .in_data  (in_data),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .tx_busy  (tx_busy),
    .buf_pop  (buf_pop),
    .buf_data (buf_data),
    .buf_count(buf_count)
  );

  packet_tx u_packet_tx (
    .tb_clk       (tb_clk),
    .reset        (reset),
    .in_token_seen(in_token_seen),
    .buf_count    (buf_count),
    .buf_data     (buf_data),
    .buf_pop      (buf_pop),
    .tx_busy      (tx_busy),
    .dplus_out    (dplus_out),
    .dminus_out   (dminus_out),
    .d_mode       (d_mode)
  );

endmodule

//--- tb_usb_in_ep.sv
// Testbench for the USB IN endpoint
// Golden file reader, token encoder, response decoder, compare tasks, timeout
`timescale 1ns/100ps
`include "usb_in_ep_defs.svh"

module tb_usb_in_ep;
  import usb_pkg::*;

  localparam int BIT_CYC = `USB_BIT_CYCLES;
  localparam int TA_BITS = `USB_TURNAROUND_BITS;
  localparam int STUFF   = `USB_STUFF_RUN;

  logic  tb_clk;
  logic  reset;
  byte_t in_data;
  logic  in_valid;
  logic  in_ready;
  logic  dplus_in;
  logic  dminus_in;
  logic  dplus_out;
  logic  dminus_out;
  logic  d_mode;

  // Parsed golden records with payload bytes in one flat queue
  string       rec_kind[$];
  int          rec_n[$];
  int          rec_off[$];
  logic [3:0]  rec_pid[$];
  logic [6:0]  rec_addr[$];
  logic [3:0]  rec_endp[$];
  logic [4:0]  rec_crc5[$];
  logic [15:0] rec_crc16[$];
  byte_t       rec_data[$];

  byte_t rx_bytes[$];
  byte_t pend_q[$];
  logic  loader_busy;
  int    cycle_cnt;
  int    cycle_limit;

  usb_in_ep u_dut (
    .tb_clk    (tb_clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .dplus_in  (dplus_in),
    .dminus_in (dminus_in),
    .dplus_out (dplus_out),
    .dminus_out(dminus_out),
    .d_mode    (d_mode)
  );

  initial begin
    tb_clk = 1'b0;
    forever #2 tb_clk = ~tb_clk;
  end

  // ****************************************
  // Watchdog
  // ****************************************
  always @(posedge tb_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("=== FAIL ===");
      $fatal(1, "Timeout");
    end
  end

  task automatic fail(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Check failed");
  endtask

  // ****************************************
  // Compare tasks
  // ****************************************
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_pid(input string name, input usb_pid_t got, input usb_pid_t exp);
    if (got !== exp) begin
      fail($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      fail($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_crc16(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      fail($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // ****************************************
  // Golden file
  // ****************************************
  task automatic read_golden();
    int    fd;
    int    code;
    int    n;
    int    val;
    int    pid;
    int    addr;
    int    endp;
    int    crc5;
    int    crc16;
    int    total;
    string word;
    string cnt_word;
    string rest;
    fd = $fopen("usb_in_ep_golden.txt", "r");
    if (fd == 0) begin
      fail("Cannot open usb_in_ep_golden.txt");
    end
    total = 0;
    while ($fscanf(fd, "%s", word) == 1) begin
      if (word.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
        continue;
      end
      n     = 0;
      pid   = 0;
      addr  = 0;
      endp  = 0;
      crc5  = 0;
      crc16 = 0;
      rec_off.push_back(rec_data.size());
      if (word == "L" || word == "P") begin
        code = $fscanf(fd, "%d", n);
        total += n;
      end else if (word == "T") begin
        code = $fscanf(fd, "%h %h %h %h", pid, addr, endp, crc5);
        // Idle, sync, PID, token, stuffing and EOP
        total += 50;
      end else if (word == "E") begin
        code = $fscanf(fd, "%h %s", pid, cnt_word);
        n = (cnt_word == "none") ? 0 : cnt_word.atoi();
        total += TA_BITS + (n + 4) * 10 + 8;
      end else if (word == "N") begin
        total += TA_BITS + 44;
      end else begin
        fail($sformatf("Unknown record kind %s in golden file", word));
      end
      for (int k = 0; k < n; k++) begin
        code = $fscanf(fd, "%h", val);
        rec_data.push_back(byte_t'(val));
      end
      if (word == "E" && n > 0) begin
        code = $fscanf(fd, "%h", crc16);
      end
      rec_kind.push_back(word);
      rec_n.push_back(n);
      rec_pid.push_back(4'(pid));
      rec_addr.push_back(7'(addr));
      rec_endp.push_back(4'(endp));
      rec_crc5.push_back(5'(crc5));
      rec_crc16.push_back(16'(crc16));
    end
    $fclose(fd);
    cycle_limit = total * BIT_CYC + 500;
  endtask

  // ****************************************
  // Line model
  // ****************************************
  // One bit time on the input pair from a falling edge
  task automatic drive_level(input logic dp, input logic dm);
    dplus_in  = dp;
    dminus_in = dm;
    repeat (BIT_CYC) @(negedge tb_clk);
  endtask

  task automatic send_token(input logic [3:0] pid, input logic [6:0] addr,
                            input logic [3:0] endp, input logic [4:0] crc5);
    logic [31:0] bits;
    logic        lvl;
    int          ones;
    bits = {`USB_SYNC_BYTE, pid, ~pid, addr, endp, crc5};
    lvl  = 1'b1;
    ones = 0;
    // Idle J ahead of sync
    repeat (3) drive_level(1'b1, 1'b0);
    for (int i = 31; i >= 0; i--) begin
      // Zero toggles and one holds
      if (!bits[i]) begin
        lvl = ~lvl;
      end
      drive_level(lvl, ~lvl);
      ones = bits[i] ? ones + 1 : 0;
      if (ones == STUFF) begin
        lvl = ~lvl;
        drive_level(lvl, ~lvl);
        ones = 0;
      end
    end
    // EOP as two SE0 bits then J
    drive_level(1'b0, 1'b0);
    drive_level(1'b0, 1'b0);
    drive_level(1'b1, 1'b0);
  endtask

  // Stuffed zeros a packet needs from its first sync bit
  function automatic int count_stuffs(input byte_t pkt[$]);
    int ones;
    int n;
    ones = 0;
    n    = 0;
    foreach (pkt[k]) begin
      for (int i = 7; i >= 0; i--) begin
        ones = pkt[k][i] ? ones + 1 : 0;
        if (ones == STUFF) begin
          n++;
          ones = 0;
        end
      end
    end
    return n;
  endfunction

  // Decode one response into rx_bytes with samples on falling edges
  task automatic decode_packet(output int stuffs);
    logic       prev;
    logic       dp;
    logic       dm;
    logic       b;
    logic [7:0] acc;
    int         ones;
    int         nbits;
    rx_bytes.delete();
    prev   = 1'b1;
    acc    = 8'h00;
    ones   = 0;
    nbits  = 0;
    stuffs = 0;
    while (!d_mode) @(negedge tb_clk);
    forever begin
      repeat (BIT_CYC) @(negedge tb_clk);
      dp = dplus_out;
      dm = dminus_out;
      if (!dp && !dm) begin
        break;
      end
      if (dp == dm) begin
        fail("Both output lines high inside a packet");
      end
      b    = (dp == prev);
      prev = dp;
      if (ones == STUFF) begin
        if (b) begin
          fail("Missing stuffed zero after a run of ones");
        end
        stuffs++;
        ones = 0;
      end else begin
        ones = b ? ones + 1 : 0;
        acc  = {acc[6:0], b};
        nbits++;
        if (nbits % 8 == 0) begin
          rx_bytes.push_back(acc);
        end
      end
    end
    if (nbits % 8 != 0) begin
      fail("Response length is not a whole number of bytes");
    end
    repeat (BIT_CYC) @(negedge tb_clk);
    if (dplus_out || dminus_out) begin
      fail("EOP is shorter than two SE0 bit times");
    end
    repeat (BIT_CYC) @(negedge tb_clk);
    if (!(dplus_out && !dminus_out)) begin
      fail("EOP does not end in J");
    end
    repeat (BIT_CYC) @(negedge tb_clk);
    check_bit("d_mode", d_mode, 1'b0);
  endtask

  // ****************************************
  // Record handlers
  // ****************************************
  task automatic load_bytes(input byte_t data[$]);
    foreach (data[k]) begin
      in_data  = data[k];
      in_valid = 1'b1;
      // Held byte waits out back-pressure
      while (!in_ready) @(negedge tb_clk);
      if (d_mode) begin
        fail("Load port took a byte while d_mode was high");
      end
      @(negedge tb_clk);
    end
    in_valid = 1'b0;
  endtask

  task automatic check_response(input int r);
    byte_t      exp_q[$];
    logic [3:0] pid;
    int         n;
    int         stuffs;
    pid = rec_pid[r];
    n   = rec_n[r];
    exp_q.push_back(`USB_SYNC_BYTE);
    exp_q.push_back({pid, ~pid});
    for (int k = 0; k < n; k++) begin
      exp_q.push_back(rec_data[rec_off[r] + k]);
    end
    if (n > 0) begin
      exp_q.push_back(rec_crc16[r][15:8]);
      exp_q.push_back(rec_crc16[r][7:0]);
    end
    decode_packet(stuffs);
    if (rx_bytes.size() != exp_q.size()) begin
      fail($sformatf("Response has %0d bytes where %0d were expected",
                     rx_bytes.size(), exp_q.size()));
    end
    check_byte("sync", rx_bytes[0], exp_q[0]);
    check_pid("pid", usb_pid_t'(rx_bytes[1][7:4]), usb_pid_t'(pid));
    check_byte("pid_byte", rx_bytes[1], exp_q[1]);
    for (int k = 0; k < n; k++) begin
      check_byte($sformatf("data[%0d]", k), rx_bytes[k + 2], exp_q[k + 2]);
    end
    if (n > 0) begin
      check_crc16("crc16", {rx_bytes[n + 2], rx_bytes[n + 3]}, rec_crc16[r]);
    end
    if (stuffs != count_stuffs(exp_q)) begin
      fail($sformatf("Found %0d stuffed zeros where %0d were expected",
                     stuffs, count_stuffs(exp_q)));
    end
  endtask

  task automatic run_record(input int r);
    byte_t slice[$];
    for (int k = 0; k < rec_n[r]; k++) begin
      slice.push_back(rec_data[rec_off[r] + k]);
    end
    if (rec_kind[r] == "L") begin
      while (loader_busy) @(negedge tb_clk);
      load_bytes(slice);
    end else if (rec_kind[r] == "P") begin
      // Loader raises in_valid once the next response is on the bus
      pend_q      = slice;
      loader_busy = 1'b1;
      fork
        begin
          while (!d_mode) @(negedge tb_clk);
          load_bytes(pend_q);
          loader_busy = 1'b0;
        end
      join_none
    end else if (rec_kind[r] == "T") begin
      send_token(rec_pid[r], rec_addr[r], rec_endp[r], rec_crc5[r]);
    end else if (rec_kind[r] == "E") begin
      check_response(r);
      while (loader_busy) @(negedge tb_clk);
    end else begin
      repeat ((TA_BITS + 40) * BIT_CYC) begin
        @(negedge tb_clk);
        if (d_mode) begin
          fail("d_mode rose in answer to a token that should be ignored");
        end
      end
    end
  endtask

  // ****************************************
  // Main sequence
  // ****************************************
  initial begin
    reset       = 1'b1;
    in_data     = 8'h00;
    in_valid    = 1'b0;
    dplus_in    = 1'b1;
    dminus_in   = 1'b0;
    loader_busy = 1'b0;
    cycle_cnt   = 0;
    cycle_limit = 100000;
    read_golden();
    repeat (3) @(posedge tb_clk);
    @(negedge tb_clk);
    reset = 1'b0;
    // Idle state after reset
    check_bit("d_mode", d_mode, 1'b0);
    check_bit("dplus_out", dplus_out, 1'b1);
    check_bit("in_ready", in_ready, 1'b1);
    foreach (rec_kind[r]) begin
      run_record(r);
    end
    while (loader_busy) @(negedge tb_clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- usb_in_ep.f
+incdir+.
usb_pkg.sv
token_rx.sv
payload_buf.sv
packet_tx.sv
usb_in_ep.sv
tb_usb_in_ep.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the USB IN endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_usb_in_ep -f usb_in_ep.f \
  --Mdir obj_dir -o sim_usb_in_ep > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_usb_in_ep > sim.log 2>&1
status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

//--- usb_in_ep_golden.txt
# L n bytes | P n bytes (held during next response) | T pid addr endp crc5
# E pid n|none bytes crc16 | N (token must get no response)
L 8 ff ff 01 80 05 ff 02 03
T 9 05 1 10
E 3 8 ff ff 01 80 05 ff 02 03 7ffa
T 9 05 1 10
E a none
T 9 05 1 11
N
T 9 06 1 10
N
T 1 05 1 10
N
L 4 ff ff ff ff
T 9 05 1 10
E 3 4 ff ff ff ff 7ff2
L 64 ff ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
T 9 05 1 10
E 3 64 ff ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 ffff
L 2 ff ff
P 4 ff ff 01 80
T 9 05 1 10
E 3 2 ff ff ffff
T 9 05 1 10
E 3 4 ff ff 01 80 faff
